//--- build.f
+incdir+logic
logic/loader_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/flash_port.sv
logic/transfer_engine.sv
logic/flash_loader_top.sv
bench/flash_loader_chk.sv
bench/flash_loader_tb.sv

//--- Makefile
TOOL = verilator
FLAGS = --binary --timing --assert -j 0
TOP = flash_loader_tb
FILELIST = build.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/flash_loader_tb.sv
// Testbench with UART host model, flash memory model, reference model, checks and watchdog.
`timescale 1ns/1ns
`include "loader_macros.svh"

module flash_loader_tb;
	import loader_pkg::*;

	localparam int FRAME = 10 * `CLKS_PER_BIT; // Clocks per UART byte.
	localparam int N_TESTS = 6;
	localparam int N_JUNK = 6;
	localparam int MAX_BYTES = N_JUNK + N_TESTS * 75; // Worst case, both lines.
	localparam int TIMEOUT_NS = MAX_BYTES * FRAME * 40 * 2 + 100000;

	logic clk;
	logic rst;
	logic rxd;
	word_t flash_rdata = '0;
	logic txd;
	flash_addr_t flash_addr;
	word_t flash_wdata;
	logic flash_data_oe;
	logic flash_ce_n;
	logic flash_oe_n;
	logic flash_we_n;

	word_t mem [256]; // Flash memory model.
	word_t ref_mem [256]; // Expected flash contents.
	logic [`FLASH_ADDR_BITS-1:8] page; // Upper address bits of the running command.
	logic [31:0] rng;
	int value_errors;
	int other_errors;
	logic quiet_mon = 1'b0;
	int quiet_hits = 0;

	flash_loader_top dut_i (
		.clk(clk),
		.rst(rst),
		.rxd(rxd),
		.flash_rdata(flash_rdata),
		.txd(txd),
		.flash_addr(flash_addr),
		.flash_wdata(flash_wdata),
		.flash_data_oe(flash_data_oe),
		.flash_ce_n(flash_ce_n),
		.flash_oe_n(flash_oe_n),
		.flash_we_n(flash_we_n)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic word_t fill_word(input int k);
		return 16'(k * 40503) ^ 16'h3a71; // Odd multiplier spreads every address bit.
	endfunction

	always @(posedge clk) begin
		if (!rst) begin
			for (int k = 0; k < 256; k++)
				mem[k] <= fill_word(k);
		end else if (!flash_we_n && !flash_ce_n && flash_data_oe
				&& flash_addr[`FLASH_ADDR_BITS-1:8] == page) begin
			mem[flash_addr[7:0]] <= flash_wdata;
		end
		if (!flash_oe_n && !flash_ce_n && flash_addr[`FLASH_ADDR_BITS-1:8] == page)
			flash_rdata <= mem[flash_addr[7:0]];
		else
			flash_rdata <= '1; // Undriven bus reads high.
	end

	// Idle line and strobes while no command is running.
	always @(negedge clk) begin
		if (quiet_mon && (txd !== 1'b1 || flash_ce_n !== 1'b1 || flash_oe_n !== 1'b1
				|| flash_we_n !== 1'b1)) begin
			if (quiet_hits == 0)
				$display("Activity on txd or a flash strobe while idle at %0t ns.", $time);
			quiet_hits++;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic draw_random(output logic [31:0] r);
		rng = xorshift(rng);
		r = rng;
	endtask

	function automatic byte_t addr_checksum(input logic [23:0] s, input logic [23:0] e);
		return `CHECKSUM_INIT ^ s[23:16] ^ s[15:8] ^ s[7:0] ^ e[23:16] ^ e[15:8] ^ e[7:0];
	endfunction

	task automatic check_byte(input byte_t got, input byte_t exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s is %04h, expected %04h", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic send_byte(input byte_t b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0}; // Start bit first, LSB first.
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			rxd <= frame[i];
			repeat (`CLKS_PER_BIT - 1) @(posedge clk);
		end
	endtask

	task automatic send_header(input byte_t cmd, input logic [23:0] s, input logic [23:0] e);
		send_byte(cmd);
		send_byte(s[23:16]);
		send_byte(s[15:8]);
		send_byte(s[7:0]);
		send_byte(e[23:16]);
		send_byte(e[15:8]);
		send_byte(e[7:0]);
	endtask

	task automatic recv_byte(input int window, output byte_t b, output bit ok);
		int waited;
		waited = 0;
		b = '0;
		ok = 1'b0;
		@(negedge clk);
		while (txd !== 1'b0 && waited < window) begin
			@(negedge clk);
			waited++;
		end
		if (txd !== 1'b0) begin
			$display("No start bit on txd within %0d clocks at %0t ns.", window, $time);
			other_errors++;
			return;
		end
		repeat (`CLKS_PER_BIT / 2) @(negedge clk); // Middle of the start bit.
		for (int i = 0; i < 8; i++) begin
			repeat (`CLKS_PER_BIT) @(negedge clk);
			b[i] = txd;
		end
		repeat (`CLKS_PER_BIT) @(negedge clk);
		if (txd !== 1'b1) begin
			$display("Stop bit on txd was low at %0t ns.", $time);
			other_errors++;
			return;
		end
		ok = 1'b1;
	endtask

	task automatic write_range(input logic [23:0] start24, input int len);
		logic [23:0] end24;
		logic [31:0] r;
		logic [7:0] idx;
		byte_t got;
		byte_t sum;
		bit ok;
		word_t words [8];
		end24 = start24 + 24'(len);
		page = start24[`FLASH_ADDR_BITS-1:8];
		fork
			send_header(`CMD_WRITE, start24, end24);
			recv_byte(7 * FRAME + 40, got, ok);
		join
		if (!ok)
			return;
		check_byte(got, addr_checksum(start24, end24), "write address ack");
		sum = `CHECKSUM_INIT;
		for (int i = 0; i < len; i++) begin
			draw_random(r);
			words[i] = r[15:0];
			idx = start24[7:0] + 8'(i);
			ref_mem[idx] = words[i];
			sum = sum ^ words[i][15:8] ^ words[i][7:0];
		end
		fork
			for (int i = 0; i < len; i++) begin
				send_byte(words[i][15:8]);
				send_byte(words[i][7:0]);
			end
			recv_byte(2 * len * FRAME + 40, got, ok);
		join
		if (!ok)
			return;
		check_byte(got, sum, "write data checksum");
		for (int k = 0; k < 256; k++)
			check_word(mem[k], ref_mem[k], $sformatf("flash word %0d after write", k));
	endtask

	task automatic read_range(input logic [23:0] start24, input int len);
		logic [23:0] end24;
		logic [7:0] idx;
		byte_t high;
		byte_t low;
		byte_t sum;
		bit ok;
		end24 = start24 + 24'(len);
		page = start24[`FLASH_ADDR_BITS-1:8];
		fork
			send_header(`CMD_READ, start24, end24);
			recv_byte(7 * FRAME + 40, high, ok);
		join
		if (!ok)
			return;
		check_byte(high, addr_checksum(start24, end24), "read address ack");
		sum = `CHECKSUM_INIT;
		for (int i = 0; i < len; i++) begin
			idx = start24[7:0] + 8'(i);
			recv_byte(2 * FRAME, high, ok);
			if (!ok)
				return;
			recv_byte(2 * FRAME, low, ok);
			if (!ok)
				return;
			check_word({high, low}, ref_mem[idx], $sformatf("read word %0d", idx));
			sum = sum ^ ref_mem[idx][15:8] ^ ref_mem[idx][7:0];
		end
		recv_byte(2 * FRAME, high, ok);
		if (ok)
			check_byte(high, sum, "read data checksum");
	endtask

	initial begin
		logic [31:0] r;
		logic [23:0] wstart;
		logic [23:0] rstart;
		int wlen;
		int rlen;
		rst = 1'b0;
		rxd = 1'b1;
		page = '0;
		rng = 32'hbcbf2e4a;
		value_errors = 0;
		other_errors = 0;
		for (int k = 0; k < 256; k++)
			ref_mem[k] = fill_word(k);
		repeat (4) @(posedge clk);
		rst <= 1'b1;
		quiet_mon = 1'b1;
		repeat (20) @(posedge clk);
		for (int j = 0; j < N_JUNK; j++) begin
			do
				draw_random(r);
			while (r[7:0] == `CMD_WRITE || r[7:0] == `CMD_READ);
			send_byte(r[7:0]);
		end
		repeat (3 * FRAME) @(posedge clk);
		quiet_mon = 1'b0;
		if (quiet_hits != 0)
			other_errors++;
		for (int t = 0; t < N_TESTS; t++) begin
			draw_random(r);
			wstart = {r[31:16], r[15:8] % 8'd240}; // Range stays inside the 256-word model.
			wlen = int'(r[2:0]) + 1;
			write_range(wstart, wlen);
			draw_random(r);
			rstart = {wstart[23:8], wstart[7:0] + 8'(int'(r[7:0]) % wlen)};
			rlen = int'(r[10:8]) + 1;
			read_range(rstart, rlen); // Follows the write with no idle gap.
			draw_random(r);
			rstart = {r[31:16], r[15:8] % 8'd240};
			rlen = int'(r[2:0]) + 1;
			read_range(rstart, rlen);
		end
		$display("errors: %0d value, %0d protocol", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns.", TIMEOUT_NS);
		$display("errors: %0d value, %0d protocol", value_errors, other_errors);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- bench/flash_loader_chk.sv
// Concurrent assertions on flash strobe exclusion, flash data enable window and txd after reset.
`timescale 1ns/1ns

module flash_loader_chk (
	input logic clk,
	input logic rst,
	input logic txd,
	input logic flash_data_oe,
	input logic flash_oe_n,
	input logic flash_we_n
);
	a_strobe_excl: assert property (@(posedge clk) disable iff (!rst)
		!(!flash_oe_n && !flash_we_n))
		else $error("flash_oe_n and flash_we_n are low together");

	// Outside the write strobe only the setup and release cycles may drive data.
	a_data_oe_window: assert property (@(posedge clk) disable iff (!rst)
		(flash_data_oe && flash_we_n) |-> (!$past(flash_data_oe) || !$past(flash_we_n)))
		else $error("flash_data_oe is high outside a write cycle");

	a_txd_idle: assert property (@(posedge clk) $rose(rst) |=> txd)
		else $error("txd is not high after reset");

endmodule

bind flash_loader_top flash_loader_chk chk_i (
	.clk(clk),
	.rst(rst),
	.txd(txd),
	.flash_data_oe(flash_data_oe),
	.flash_oe_n(flash_oe_n),
	.flash_we_n(flash_we_n)
);

//--- logic/flash_loader_top.sv
// Top level joining the UART receiver and transmitter, command engine and flash port.
`timescale 1ns/1ns

module flash_loader_top (
	input logic clk,
	input logic rst,
	input logic rxd,
	input loader_pkg::word_t flash_rdata,
	output logic txd,
	output loader_pkg::flash_addr_t flash_addr,
	output loader_pkg::word_t flash_wdata,
	output logic flash_data_oe,
	output logic flash_ce_n,
	output logic flash_oe_n,
	output logic flash_we_n
);
	import loader_pkg::*;

	byte_t rx_data;
	logic rx_ready;
	byte_t tx_data;
	logic tx_start;
	logic tx_busy;
	flash_addr_t addr;
	word_t wdata;
	word_t rdata;
	logic rd_en;
	logic wr_en;
	logic busy;

	uart_rx rx_i (
		.clk(clk),
		.rst(rst),
		.rxd(rxd),
		.rx_data(rx_data),
		.rx_ready(rx_ready)
	);

	uart_tx tx_i (
		.clk(clk),
		.rst(rst),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.txd(txd),
		.tx_busy(tx_busy)
	);

	transfer_engine engine_i (
		.clk(clk),
		.rst(rst),
		.rx_data(rx_data),
		.rx_ready(rx_ready),
		.tx_busy(tx_busy),
		.rdata(rdata),
		.busy(busy),
		.tx_data(tx_data),
		.tx_start(tx_start),
		.addr(addr),
		.wdata(wdata),
		.rd_en(rd_en),
		.wr_en(wr_en)
	);

	flash_port flash_i (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.wdata(wdata),
		.rd_en(rd_en),
		.wr_en(wr_en),
		.flash_rdata(flash_rdata),
		.rdata(rdata),
		.busy(busy),
		.flash_addr(flash_addr),
		.flash_wdata(flash_wdata),
		.flash_data_oe(flash_data_oe),
		.flash_ce_n(flash_ce_n),
		.flash_oe_n(flash_oe_n),
		.flash_we_n(flash_we_n)
	);

endmodule

//--- logic/transfer_engine.sv
// Command engine FSM for address parsing, checksums, and flash word write and readback.
`timescale 1ns/1ns
`include "loader_macros.svh"

module transfer_engine (
	input logic clk,
	input logic rst,
	input loader_pkg::byte_t rx_data,
	input logic rx_ready,
	input logic tx_busy,
	input loader_pkg::word_t rdata,
	input logic busy,
	output loader_pkg::byte_t tx_data,
	output logic tx_start,
	output loader_pkg::flash_addr_t addr,
	output loader_pkg::word_t wdata,
	output logic rd_en,
	output logic wr_en
);
	import loader_pkg::*;

	loader_state_t state;
	loader_state_t ret_state; // Where the transmit wait goes next.
	logic [47:0] meta; // Start then end address, MSB first.
	logic [2:0] meta_cnt;
	byte_t checksum;
	byte_t byte_buf; // High byte of a write word, or low byte of a read word.
	logic half; // A write word is half received.
	logic rd_pending;
	flash_addr_t cur_addr;
	flash_addr_t end_addr;
	flash_addr_t addr_next;

	assign addr_next = cur_addr + 1'b1;

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= st_idle;
			ret_state <= st_idle;
			meta_cnt <= '0;
			checksum <= `CHECKSUM_INIT;
			half <= 1'b0;
			rd_pending <= 1'b0;
			tx_start <= 1'b0;
			rd_en <= 1'b0;
			wr_en <= 1'b0;
		end else begin
			rd_en <= 1'b0; // Flash enables are single-cycle pulses.
			wr_en <= 1'b0;
			case (state)
				st_idle: begin
					checksum <= `CHECKSUM_INIT;
					meta_cnt <= '0;
					if (rx_ready && rx_data == `CMD_WRITE) begin
						state <= st_recv_meta;
						ret_state <= st_write_recv;
					end else if (rx_ready && rx_data == `CMD_READ) begin
						state <= st_recv_meta;
						ret_state <= st_read_flash;
					end
				end
				st_recv_meta:
					if (rx_ready) begin
						meta <= {meta[39:0], rx_data};
						checksum <= checksum ^ rx_data;
						meta_cnt <= meta_cnt + 1'b1;
						if (meta_cnt == 3'd5)
							state <= st_meta_ack;
					end
				st_meta_ack: begin
					cur_addr <= meta[24 +: `FLASH_ADDR_BITS];
					end_addr <= meta[0 +: `FLASH_ADDR_BITS];
					tx_data <= checksum;
					tx_start <= 1'b1;
					checksum <= `CHECKSUM_INIT;
					half <= 1'b0;
					state <= st_wait_tx; // Return state was chosen by the command.
				end

				st_write_recv:
					if (rx_ready) begin
						checksum <= checksum ^ rx_data;
						half <= !half;
						if (!half) begin
							byte_buf <= rx_data;
						end else begin
							addr <= cur_addr;
							wdata <= {byte_buf, rx_data};
							wr_en <= 1'b1;
							cur_addr <= addr_next;
							if (addr_next == end_addr)
								state <= st_write_ack;
						end
					end
				st_write_ack:
					if (!wr_en && !busy) begin // Last write has finished.
						tx_data <= checksum;
						tx_start <= 1'b1;
						ret_state <= st_idle;
						state <= st_wait_tx;
					end

				st_read_flash:
					if (!rd_pending) begin
						addr <= cur_addr;
						rd_en <= 1'b1;
						rd_pending <= 1'b1;
					end else if (!rd_en && !busy) begin
						rd_pending <= 1'b0;
						checksum <= checksum ^ rdata[15:8] ^ rdata[7:0];
						tx_data <= rdata[15:8];
						byte_buf <= rdata[7:0];
						tx_start <= 1'b1;
						cur_addr <= addr_next;
						ret_state <= st_send_high;
						state <= st_wait_tx;
					end
				st_send_high: begin
					tx_data <= byte_buf;
					tx_start <= 1'b1;
					ret_state <= st_send_low;
					state <= st_wait_tx;
				end
				st_send_low:
					if (cur_addr == end_addr) begin
						tx_data <= checksum;
						tx_start <= 1'b1;
						ret_state <= st_idle;
						state <= st_wait_tx;
					end else begin
						state <= st_read_flash;
					end

				// Hold the start level until the transmitter takes it.
				st_wait_tx:
					if (tx_busy) begin
						tx_start <= 1'b0;
						state <= st_wait_tx_done;
					end
				st_wait_tx_done:
					if (!tx_busy)
						state <= ret_state;

				default:
					state <= st_idle;
			endcase
		end
	end

endmodule

//--- logic/flash_port.sv
// Flash bus sequencer with setup, strobe and release phases for single-word reads and writes.
`timescale 1ns/1ns
`include "loader_macros.svh"

module flash_port (
	input logic clk,
	input logic rst,
	input loader_pkg::flash_addr_t addr,
	input loader_pkg::word_t wdata,
	input logic rd_en,
	input logic wr_en,
	input loader_pkg::word_t flash_rdata,
	output loader_pkg::word_t rdata,
	output logic busy,
	output loader_pkg::flash_addr_t flash_addr,
	output loader_pkg::word_t flash_wdata,
	output logic flash_data_oe,
	output logic flash_ce_n,
	output logic flash_oe_n,
	output logic flash_we_n
);
	localparam logic [2:0] RD_LAST = 3'(`FLASH_RD_CYCLES - 1);
	localparam logic [2:0] WR_LAST = 3'(`FLASH_WR_CYCLES - 1);

	typedef enum logic [1:0] {fp_idle, fp_setup, fp_strobe, fp_release} fp_state_t;

	fp_state_t state;
	logic is_write;
	logic [2:0] strobe_cnt;

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= fp_idle;
			is_write <= 1'b0;
			strobe_cnt <= '0;
			busy <= 1'b0;
			flash_data_oe <= 1'b0;
			flash_ce_n <= 1'b1;
			flash_oe_n <= 1'b1;
			flash_we_n <= 1'b1;
		end else begin
			case (state)
				fp_idle:
					if (rd_en || wr_en) begin
						state <= fp_setup;
						busy <= 1'b1;
						is_write <= wr_en;
						flash_addr <= addr; // Held for the whole cycle.
						flash_wdata <= wdata;
						flash_ce_n <= 1'b0;
						flash_data_oe <= wr_en;
						strobe_cnt <= wr_en ? WR_LAST : RD_LAST;
					end
				fp_setup: begin
					state <= fp_strobe;
					if (is_write)
						flash_we_n <= 1'b0;
					else
						flash_oe_n <= 1'b0;
				end
				fp_strobe:
					if (strobe_cnt == '0) begin
						state <= fp_release;
						flash_oe_n <= 1'b1;
						flash_we_n <= 1'b1;
						if (!is_write)
							rdata <= flash_rdata; // Sampled on the last strobe cycle.
					end else begin
						strobe_cnt <= strobe_cnt - 1'b1;
					end
				fp_release: begin
					state <= fp_idle;
					busy <= 1'b0;
					flash_ce_n <= 1'b1;
					flash_data_oe <= 1'b0;
				end
				default:
					state <= fp_idle;
			endcase
		end
	end

endmodule

//--- logic/uart_tx.sv
// UART transmitter with start pulse, frame shifter and busy flag.
`timescale 1ns/1ns
`include "loader_macros.svh"

module uart_tx (
	input logic clk,
	input logic rst,
	input logic tx_start,
	input loader_pkg::byte_t tx_data,
	output logic txd,
	output logic tx_busy
);
	localparam int CNT_W = $clog2(`CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`CLKS_PER_BIT - 1);

	logic [8:0] shift; // Data bits followed by the stop bit.
	logic [3:0] bit_cnt; // Bits still to go after the current one.
	logic [CNT_W-1:0] clk_cnt;

	always_ff @(posedge clk) begin
		if (!rst) begin
			txd <= 1'b1;
			tx_busy <= 1'b0;
			bit_cnt <= '0;
			clk_cnt <= '0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				tx_busy <= 1'b1;
				txd <= 1'b0; // Start bit.
				shift <= {1'b1, tx_data};
				bit_cnt <= 4'd9;
				clk_cnt <= FULL_BIT;
			end
		end else if (clk_cnt != '0) begin
			clk_cnt <= clk_cnt - 1'b1;
		end else if (bit_cnt != '0) begin
			txd <= shift[0];
			shift <= {1'b1, shift[8:1]};
			bit_cnt <= bit_cnt - 1'b1;
			clk_cnt <= FULL_BIT;
		end else begin
			tx_busy <= 1'b0; // Stop bit has run its full time.
		end
	end

endmodule

//--- logic/uart_rx.sv
// UART receiver with two-flop input synchroniser, mid-bit sampling and stop bit check.
`timescale 1ns/1ns
`include "loader_macros.svh"

module uart_rx (
	input logic clk,
	input logic rst,
	input logic rxd,
	output loader_pkg::byte_t rx_data,
	output logic rx_ready
);
	import loader_pkg::*;

	localparam int CNT_W = $clog2(`CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`CLKS_PER_BIT - 1);

	logic rxd_meta;
	logic rxd_sync;
	logic active;
	logic [3:0] bit_cnt; // 0 start, 1 to 8 data, 9 stop.
	logic [CNT_W-1:0] clk_cnt;
	byte_t shift;

	always_ff @(posedge clk) begin
		if (!rst) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			active <= 1'b0;
			bit_cnt <= '0;
			clk_cnt <= '0;
			rx_ready <= 1'b0;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rx_ready <= 1'b0;
			if (!active) begin
				if (!rxd_sync) begin // Falling edge of a start bit.
					active <= 1'b1;
					bit_cnt <= '0;
					clk_cnt <= HALF_BIT;
				end
			end else if (clk_cnt != '0) begin
				clk_cnt <= clk_cnt - 1'b1;
			end else begin
				clk_cnt <= FULL_BIT;
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == 4'd0) begin
					if (rxd_sync)
						active <= 1'b0; // Glitch, not a start bit.
				end else if (bit_cnt != 4'd9) begin
					shift <= {rxd_sync, shift[7:1]}; // LSB arrives first.
				end else begin
					active <= 1'b0;
					if (rxd_sync) begin // Framing error drops the byte.
						rx_ready <= 1'b1;
						rx_data <= shift;
					end
				end
			end
		end
	end

endmodule

//--- logic/loader_pkg.sv
// Vector typedefs for bytes, flash words and word addresses, and the engine state enum.
`include "loader_macros.svh"

package loader_pkg;

	typedef logic [7:0] byte_t; // UART byte or checksum.
	typedef logic [15:0] word_t; // One flash word.
	typedef logic [`FLASH_ADDR_BITS-1:0] flash_addr_t; // Flash word address.

	typedef enum logic [3:0] {
		st_idle,
		st_recv_meta,
		st_meta_ack,
		st_write_recv,
		st_write_ack,
		st_read_flash,
		st_send_high,
		st_send_low,
		st_wait_tx,
		st_wait_tx_done
	} loader_state_t;

endpackage

//--- logic/loader_macros.svh
// Command codes, checksum seed, flash address width, UART bit time and flash cycle lengths.
`ifndef LOADER_MACROS_SVH
`define LOADER_MACROS_SVH

`define CMD_WRITE 8'hf3 // Host writes a word range.
`define CMD_READ 8'h2a // Host reads a word range back.

`define CHECKSUM_INIT 8'h23 // Seed of both checksums.

`define FLASH_ADDR_BITS 22 // Low bits kept from the 24-bit address field.

`define CLKS_PER_BIT 8 // Short bit time for simulation.

// Strobe phase length of one flash cycle, in clocks.
`define FLASH_RD_CYCLES 3
`define FLASH_WR_CYCLES 4

`endif
